// ==== flist.f ====
+incdir+.
wb_bus_pkg.sv
wb_route_pkg.sv
wb_grant_mux.sv
wb_rr_arbiter.sv
wb_master_port.sv
wb_target_port.sv
wb_decode_err_target.sv
wb_interconnect_3x1.sv
wb_mem_slave_model.sv
wb_interconnect_3x1_tb.sv

// ==== wb_bus_pkg.sv ====
////////////////////
// Wishbone classic request and
// response bundles
////////////////////

`default_nettype none

`include "wb_xbar_consts.svh"

package wb_bus_pkg;

	// Master to slave, held stable until ack or err
	typedef struct packed {
		logic                       cyc;
		logic                       stb;
		logic                       we;
		logic [`WB_ADDR_W-1:0]      adr;
		logic [(`WB_DATA_W/8)-1:0]  sel;
		logic [`WB_DATA_W-1:0]      dat_w;
		logic [2:0]                 cti;
		logic [1:0]                 bte;
	} wb_req_t;

	// Slave to master, valid only in the ack or err cycle
	typedef struct packed {
		logic                   ack;
		logic                   err;
		logic [`WB_DATA_W-1:0]  dat_r;
	} wb_rsp_t;

endpackage

`default_nettype wire

// ==== wb_decode_err_target.sv ====
////////////////////
// Target answering every access
// with ack and err, no data
////////////////////

`timescale 1ns/10ps
`default_nettype none

module wb_decode_err_target import wb_bus_pkg::*; (
	input  wire           clk,
	input  wire           rstn,
	input  wire wb_req_t  req_i,
	output wb_rsp_t       rsp_o
);

	logic access;
	logic resp_q;
	logic done_q;

	assign access = req_i.cyc && req_i.stb;

	always_ff @(posedge clk) begin
		if (!rstn) begin
			resp_q <= 1'b0;
			done_q <= 1'b0;
		end else begin
			resp_q <= access && !resp_q && !done_q;
			// Quiet after a response until stb drops
			done_q <= (resp_q || done_q) && req_i.stb;
		end
	end

	assign rsp_o = '{ack: resp_q, err: resp_q, dat_r: '0};

	// The request must still be on the bus in the response cycle
	a_no_spurious_rsp: assert property (@(posedge clk) disable iff (!rstn)
		rsp_o.ack |-> access)
		else $error("decode-error target responded without an access");

endmodule

`default_nettype wire

// ==== wb_grant_mux.sv ====
////////////////////
// Selector passing one of N payloads,
// or all zeros when disabled
////////////////////

`timescale 1ns/10ps
`default_nettype none

module wb_grant_mux #(
	parameter int N = 2,
	parameter type T = logic [7:0],
	localparam int SEL_W = (N > 1) ? $clog2(N) : 1
) (
	input  wire T                data_i [N],
	input  wire logic [SEL_W-1:0] sel_i,
	input  wire logic            en_i,
	output T                     data_o
);

	always_comb begin
		data_o = '0;
		// Out of range select behaves like no owner
		if (en_i && (int'(sel_i) < N)) begin
			data_o = data_i[sel_i];
		end
	end

endmodule

`default_nettype wire

// ==== wb_interconnect_3x1.sv ====
////////////////////
// Wishbone shared-bus interconnect,
// three masters onto slave 0 plus an
// internal decode-error target
////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "wb_xbar_consts.svh"

module wb_interconnect_3x1 import wb_bus_pkg::*, wb_route_pkg::*; (
	input  wire           clk,
	input  wire           rstn,
	input  wire wb_req_t  m_req_i [`WB_N_MASTERS],
	output wb_rsp_t       m_rsp_o [`WB_N_MASTERS],
	output wb_req_t       s0_req_o,
	input  wire wb_rsp_t  s0_rsp_i
);

	// Stage 1 to stage 2
	wire route_t  m_route [`WB_N_MASTERS];

	// Stage 2 to targets and back
	wire grant_t  t_gnt [`WB_N_TARGETS];
	wire wb_req_t t_req [`WB_N_TARGETS];
	wire wb_rsp_t t_rsp [`WB_N_TARGETS];

	for (genvar m = 0; m < `WB_N_MASTERS; m++) begin : g_mport
		wb_master_port #(
			.MASTER (m)
		) i_mport (
			.clk       (clk),
			.rstn      (rstn),
			.req_i     (m_req_i[m]),
			.route_o   (m_route[m]),
			.gnt_i     (t_gnt),
			.tgt_rsp_i (t_rsp),
			.rsp_o     (m_rsp_o[m])
		);
	end

	for (genvar t = 0; t < `WB_N_TARGETS; t++) begin : g_tport
		wb_target_port #(
			.TARGET (t)
		) i_tport (
			.clk     (clk),
			.rstn    (rstn),
			.req_i   (m_req_i),
			.route_i (m_route),
			.gnt_o   (t_gnt[t]),
			.req_o   (t_req[t])
		);
	end

	// Slave 0 sits outside
	assign s0_req_o          = t_req[TGT_SLAVE0];
	assign t_rsp[TGT_SLAVE0] = s0_rsp_i;

	// Everything outside the slave 0 window lands here
	wb_decode_err_target i_decerr (
		.clk   (clk),
		.rstn  (rstn),
		.req_i (t_req[TGT_DECERR]),
		.rsp_o (t_rsp[TGT_DECERR])
	);

endmodule

`default_nettype wire

// ==== wb_interconnect_3x1_tb.sv ====
////////////////////
// Testbench of the Wishbone 3x1
// interconnect: directed and random
// traffic, reference memory, checks
////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "wb_xbar_consts.svh"

module wb_interconnect_3x1_tb import wb_bus_pkg::*; ();

	localparam int N_M        = `WB_N_MASTERS;
	localparam int WORDS      = (`WB_S0_LIMIT - `WB_S0_BASE + 1) / 4;
	localparam int WAIT_LIMIT = 200;
	localparam int RAND_N     = 40;

	logic    clk;
	logic    rstn;
	wb_req_t m_req [N_M];
	wb_rsp_t m_rsp [N_M];
	wb_req_t s0_req;
	wb_rsp_t s0_rsp;

	integer                seed = 55;
	logic [`WB_DATA_W-1:0] shadow [WORDS];
	wb_req_t               s0_seen [$];
	wb_req_t               traffic [N_M][RAND_N];
	logic                  s0_busy_q;
	int                    last_s0;
	int                    overlap_cnt;

	wb_interconnect_3x1 i_dut (
		.clk      (clk),
		.rstn     (rstn),
		.m_req_i  (m_req),
		.m_rsp_o  (m_rsp),
		.s0_req_o (s0_req),
		.s0_rsp_i (s0_rsp)
	);

	wb_mem_slave_model #(
		.SEED (55)
	) i_slave0 (
		.clk   (clk),
		.rstn  (rstn),
		.req_i (s0_req),
		.rsp_o (s0_rsp)
	);

	always #5 clk = ~clk;

	task automatic stop_sim();
		$display("TEST FAILED");
		$fatal(1, "stopping at first failure");
	endtask

	task automatic fail_with(input string msg);
		$display("%s at %0t", msg, $time);
		stop_sim();
	endtask

	task automatic check_rsp(input string name, input wb_rsp_t got, input wb_rsp_t exp);
		if (got !== exp) begin
			$display("ERROR at %0t: %s = %h, expected %h", $time, name, got, exp);
			stop_sim();
		end
	endtask

	task automatic check_req(input string name, input wb_req_t got, input wb_req_t exp);
		if (got !== exp) begin
			$display("ERROR at %0t: %s = %h, expected %h", $time, name, got, exp);
			stop_sim();
		end
	endtask

	function automatic wb_req_t make_req(input logic we, input logic [31:0] adr,
	                                     input logic [3:0] sel, input logic [31:0] dat);
		return '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, sel: sel, dat_w: dat,
		         cti: 3'b000, bte: 2'b00};
	endfunction

	// Reference slave behavior, updates the shadow memory on writes
	function automatic wb_rsp_t ref_access(input wb_req_t req);
		wb_rsp_t rsp;
		int      idx;
		rsp     = '0;
		rsp.ack = 1'b1;
		if (req.adr < `WB_S0_BASE || req.adr > `WB_S0_LIMIT) begin
			rsp.err = 1'b1;
		end else begin
			idx = int'((req.adr - `WB_S0_BASE) >> 2);
			if (req.we) begin
				for (int b = 0; b < `WB_DATA_W / 8; b++) begin
					if (req.sel[b]) shadow[idx][8*b +: 8] = req.dat_w[8*b +: 8];
				end
			end else begin
				rsp.dat_r = shadow[idx];
			end
		end
		return rsp;
	endfunction

	// Lowest requester above the last grant, else the lowest requester
	function automatic int rr_next(input int last, input logic [N_M-1:0] pend);
		int pick;
		pick = -1;
		for (int i = N_M - 1; i >= 0; i--) begin
			if (pend[i]) pick = i;
		end
		for (int i = N_M - 1; i > last; i--) begin
			if (pend[i]) pick = i;
		end
		return pick;
	endfunction

	// Mostly a small hot region of slave 0, about a quarter outside the window
	function automatic wb_req_t rand_req();
		wb_req_t     r;
		logic [31:0] rv;
		rv = $random(seed);
		if (rv[3:2] == 2'b00) begin
			r = make_req(rv[0], {rv[31:12] | 20'h1, rv[11:2], 2'b00}, rv[19:16], $random(seed));
		end else begin
			r = make_req(rv[0], 32'h0000_0200 + {26'h0, rv[9:6], 2'b00}, rv[19:16],
			             $random(seed));
		end
		r.cti = rv[22:20];
		r.bte = rv[24:23];
		return r;
	endfunction

	task automatic do_xfer(input int m, input wb_req_t req);
		int   cnt;
		logic done;
		cnt  = 0;
		done = 1'b0;
		@(posedge clk);
		m_req[m] <= req;
		while (!done) begin
			@(posedge clk);
			done = m_rsp[m].ack || m_rsp[m].err;
			cnt++;
			if (!done && cnt > WAIT_LIMIT) begin
				fail_with($sformatf("master %0d got no response in %0d cycles", m, WAIT_LIMIT));
			end
		end
		m_req[m] <= '0;
	endtask

	task automatic run_master(input int m);
		for (int i = 0; i < RAND_N; i++) begin
			do_xfer(m, traffic[m][i]);
		end
	endtask

	// Response checker and slave 0 request monitor
	always @(posedge clk) begin
		wb_rsp_t exp;
		if (!rstn) begin
			s0_busy_q <= 1'b0;
		end else begin
			for (int m = 0; m < N_M; m++) begin
				if (m_rsp[m].ack || m_rsp[m].err) begin
					if (!m_req[m].cyc) begin
						fail_with($sformatf("master %0d got a response with no request", m));
					end
					exp = ref_access(m_req[m]);
					check_rsp($sformatf("m_rsp_o[%0d]", m), m_rsp[m], exp);
					if (m_rsp[m].err && s0_req.cyc) overlap_cnt++;
					if (!m_rsp[m].err) last_s0 = m;
				end
			end
			if (s0_req.cyc && s0_req.stb && !s0_busy_q) begin
				s0_seen.push_back(s0_req);
			end
			s0_busy_q <= s0_req.cyc;
		end
	end

	initial begin
		wb_req_t        wr;
		wb_req_t        dir [N_M];
		logic [N_M-1:0] pend;
		int             base;
		int             who;
		clk  = 1'b0;
		rstn = 1'b0;
		for (int m = 0; m < N_M; m++) begin
			m_req[m] = '0;
		end
		// No grant yet, so the first search wraps to the lowest index
		last_s0     = N_M - 1;
		overlap_cnt = 0;
		for (int i = 0; i < WORDS; i++) begin
			shadow[i] = ((32'(i) * 4 + `WB_S0_BASE) * 32'h9E37_79B1) ^ 32'h5A5A_C3C3;
		end
		repeat (8) @(posedge clk);
		rstn <= 1'b1;
		repeat (2) @(posedge clk);

		// Idle bus after reset
		for (int m = 0; m < N_M; m++) begin
			check_rsp($sformatf("m_rsp_o[%0d]", m), m_rsp[m], '0);
		end
		check_req("s0_req_o", s0_req, '0);

		// Single master write and read back
		wr = make_req(1'b1, 32'h0000_0040, 4'hF, 32'hCAFE_F00D);
		do_xfer(0, wr);
		check_req("s0_req_o", s0_seen[$], wr);
		wr = make_req(1'b0, 32'h0000_0040, 4'hF, '0);
		do_xfer(0, wr);
		check_req("s0_req_o", s0_seen[$], wr);

		// Outside the window, error target only
		base = s0_seen.size();
		do_xfer(2, make_req(1'b0, 32'h0000_2000, 4'hF, '0));
		if (s0_seen.size() != base) fail_with("slave 0 saw an out-of-window access");

		// Byte lane merging
		do_xfer(1, make_req(1'b1, 32'h0000_0080, 4'hF, 32'h1122_3344));
		for (int i = 0; i < 8; i++) begin
			do_xfer(1, make_req(1'b1, 32'h0000_0080, 4'($random(seed)), $random(seed)));
			do_xfer(1, make_req(1'b0, 32'h0000_0080, 4'hF, '0));
		end

		// All masters contend for slave 0
		@(posedge clk);
		who  = last_s0;
		base = s0_seen.size();
		for (int m = 0; m < N_M; m++) begin
			dir[m] = make_req(1'b0, 32'h0000_0100 + 32'(m * 4), 4'hF, '0);
		end
		fork
			do_xfer(0, dir[0]);
			do_xfer(1, dir[1]);
			do_xfer(2, dir[2]);
		join
		@(posedge clk);
		if (s0_seen.size() != base + N_M) fail_with("slave 0 did not see one transfer per master");
		pend = '1;
		for (int k = 0; k < N_M; k++) begin
			who = rr_next(who, pend);
			pend[who] = 1'b0;
			check_req("s0_req_o", s0_seen[base + k], dir[who]);
		end

		// Long random mix from all masters
		for (int m = 0; m < N_M; m++) begin
			for (int i = 0; i < RAND_N; i++) begin
				traffic[m][i] = rand_req();
			end
		end
		fork
			run_master(0);
			run_master(1);
			run_master(2);
		join
		@(posedge clk);
		if (overlap_cnt > 0) begin
			$display("TEST OK");
			$finish;
		end else begin
			fail_with("no error access completed while slave 0 was owned");
		end
	end

endmodule

`default_nettype wire

// ==== wb_master_port.sv ====
////////////////////
// Per-master stage: address decode
// into a registered route, and the
// response return path
////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "wb_xbar_consts.svh"

module wb_master_port import wb_bus_pkg::*, wb_route_pkg::*; #(
	parameter int MASTER = 0
) (
	input  wire           clk,
	input  wire           rstn,
	input  wire wb_req_t  req_i,
	output route_t        route_o,
	input  wire grant_t   gnt_i [`WB_N_TARGETS],
	input  wire wb_rsp_t  tgt_rsp_i [`WB_N_TARGETS],
	output wb_rsp_t       rsp_o
);

	route_t route_q;
	grant_t tgt_gnt;
	logic   in_window;
	logic   rsp_en;

	assign in_window = (req_i.adr >= `WB_S0_BASE) && (req_i.adr <= `WB_S0_LIMIT);

	always_ff @(posedge clk) begin
		if (!rstn) begin
			route_q <= '0;
		end else if (!route_q.valid) begin
			if (req_i.cyc && req_i.stb) begin
				route_q.valid  <= 1'b1;
				route_q.target <= in_window ? TGT_SLAVE0 : TGT_DECERR;
			end
		end else if (rsp_o.ack || rsp_o.err || !req_i.cyc) begin
			// Transfer finished, or the master left the bus
			route_q <= '0;
		end
	end

	assign route_o = route_q;

	// Response only counts while the routed target is owned by us
	assign tgt_gnt = gnt_i[route_q.target];
	assign rsp_en  = route_q.valid && tgt_gnt.valid &&
	                 (tgt_gnt.master == master_id_t'(MASTER));

	wb_grant_mux #(
		.N (`WB_N_TARGETS),
		.T (wb_rsp_t)
	) i_rsp_mux (
		.data_i (tgt_rsp_i),
		.sel_i  (route_q.target),
		.en_i   (rsp_en),
		.data_o (rsp_o)
	);

	// Destination cannot change under an open transfer
	a_route_stable: assert property (@(posedge clk) disable iff (!rstn)
		route_q.valid && $past(route_q.valid) |-> route_q.target == $past(route_q.target))
		else $error("master %0d route changed while valid", MASTER);

endmodule

`default_nettype wire

// ==== wb_mem_slave_model.sv ====
////////////////////
// Testbench memory slave for the
// slave 0 window, random ack latency
////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "wb_xbar_consts.svh"

module wb_mem_slave_model import wb_bus_pkg::*; #(
	parameter int SEED = 55
) (
	input  wire           clk,
	input  wire           rstn,
	input  wire wb_req_t  req_i,
	output wb_rsp_t       rsp_o
);

	localparam int WORDS = (`WB_S0_LIMIT - `WB_S0_BASE + 1) / 4;

	logic [`WB_DATA_W-1:0] mem [WORDS];
	integer                seed = SEED;
	logic                  busy_q;
	int                    wait_q;

	// Preload as a function of the whole byte address
	initial begin
		rsp_o = '0;
		for (int i = 0; i < WORDS; i++) begin
			mem[i] = ((32'(i) * 4 + `WB_S0_BASE) * 32'h9E37_79B1) ^ 32'h5A5A_C3C3;
		end
	end

	always @(posedge clk) begin
		int   lat;
		int   idx;
		logic go;
		go  = 1'b0;
		idx = int'((req_i.adr - `WB_S0_BASE) >> 2) % WORDS;
		if (!rstn) begin
			rsp_o  <= '0;
			busy_q <= 1'b0;
			wait_q <= 0;
		end else begin
			rsp_o <= '0;
			// Request is still up in the cycle after its ack
			if (req_i.cyc && req_i.stb && !rsp_o.ack) begin
				if (!busy_q) begin
					lat = 1 + int'($unsigned($random(seed)) % 4);
					go = (lat == 1);
					busy_q <= (lat != 1);
					wait_q <= lat - 2;
				end else if (wait_q != 0) begin
					wait_q <= wait_q - 1;
				end else begin
					go = 1'b1;
					busy_q <= 1'b0;
				end
			end
			if (go) begin
				rsp_o.ack <= 1'b1;
				if (req_i.we) begin
					for (int b = 0; b < `WB_DATA_W / 8; b++) begin
						if (req_i.sel[b]) mem[idx][8*b +: 8] <= req_i.dat_w[8*b +: 8];
					end
				end else begin
					rsp_o.dat_r <= mem[idx];
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== wb_route_pkg.sv ====
////////////////////
// Master and target ids, the route
// and grant records of the crossbar
////////////////////

`default_nettype none

`include "wb_xbar_consts.svh"

package wb_route_pkg;

	typedef logic [$clog2(`WB_N_MASTERS)-1:0] master_id_t;
	typedef logic [$clog2(`WB_N_TARGETS)-1:0] target_id_t;

	// Target numbering
	localparam target_id_t TGT_SLAVE0 = 1'b0;
	localparam target_id_t TGT_DECERR = 1'b1;

	// Registered destination of one master
	typedef struct packed {
		logic       valid;
		target_id_t target;
	} route_t;

	// Current owner of one target
	typedef struct packed {
		logic       valid;
		master_id_t master;
	} grant_t;

endpackage

`default_nettype wire

// ==== wb_rr_arbiter.sv ====
////////////////////
// Round-robin arbiter, grant held
// until the owner drops its request
////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "wb_xbar_consts.svh"

module wb_rr_arbiter import wb_route_pkg::*; #(
	parameter int N_REQ = `WB_N_MASTERS
) (
	input  wire              clk,
	input  wire              rstn,
	input  wire [N_REQ-1:0]  req_i,
	output grant_t           gnt_o
);

	typedef enum logic {
		ARB_IDLE,
		ARB_OWNED
	} arb_state_e;

	arb_state_e       state_q;
	master_id_t       owner_q;
	master_id_t       last_q;
	logic [N_REQ-1:0] above_mask;
	logic [N_REQ-1:0] masked_req;
	master_id_t       pick;

	function automatic master_id_t lowest_set(input logic [N_REQ-1:0] vec);
		master_id_t idx;
		idx = '0;
		for (int i = N_REQ - 1; i >= 0; i--) begin
			if (vec[i]) begin
				idx = master_id_t'(i);
			end
		end
		return idx;
	endfunction

	// Requesters strictly above the last grant
	always_comb begin
		for (int i = 0; i < N_REQ; i++) begin
			above_mask[i] = (i > int'(last_q));
		end
	end

	assign masked_req = req_i & above_mask;
	// Wrap to the lowest requester when nobody sits above the last grant
	assign pick = (|masked_req) ? lowest_set(masked_req) : lowest_set(req_i);

	always_ff @(posedge clk) begin
		if (!rstn) begin
			state_q <= ARB_IDLE;
			owner_q <= '0;
			// First grant after reset goes to the lowest requester
			last_q  <= master_id_t'(N_REQ - 1);
		end else begin
			case (state_q)
				ARB_IDLE: begin
					if (|req_i) begin
						state_q <= ARB_OWNED;
						owner_q <= pick;
						last_q  <= pick;
					end
				end
				ARB_OWNED: begin
					if (!req_i[owner_q]) begin
						state_q <= ARB_IDLE;
						owner_q <= '0;
					end
				end
			endcase
		end
	end

	assign gnt_o = '{valid: (state_q == ARB_OWNED), master: owner_q};

	// A fresh grant must land on a master that is still requesting
	a_gnt_has_req: assert property (@(posedge clk) disable iff (!rstn)
		gnt_o.valid && !$past(gnt_o.valid) |-> req_i[gnt_o.master])
		else $error("grant issued to idle master %0d", gnt_o.master);

	a_gnt_in_range: assert property (@(posedge clk) disable iff (!rstn)
		gnt_o.valid |-> (int'(gnt_o.master) < N_REQ))
		else $error("grant master %0d out of range", gnt_o.master);

endmodule

`default_nettype wire

// ==== wb_target_port.sv ====
////////////////////
// Per-target stage: round-robin
// arbitration and request forwarding
////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "wb_xbar_consts.svh"

module wb_target_port import wb_bus_pkg::*, wb_route_pkg::*; #(
	parameter int TARGET = 0
) (
	input  wire           clk,
	input  wire           rstn,
	input  wire wb_req_t  req_i [`WB_N_MASTERS],
	input  wire route_t   route_i [`WB_N_MASTERS],
	output grant_t        gnt_o,
	output wb_req_t       req_o
);

	logic [`WB_N_MASTERS-1:0] route_hit;
	logic                     fwd_en;

	// Masters whose registered route names this target
	always_comb begin
		for (int m = 0; m < `WB_N_MASTERS; m++) begin
			route_hit[m] = route_i[m].valid && (route_i[m].target == target_id_t'(TARGET));
		end
	end

	wb_rr_arbiter #(
		.N_REQ (`WB_N_MASTERS)
	) i_arb (
		.clk   (clk),
		.rstn  (rstn),
		.req_i (route_hit),
		.gnt_o (gnt_o)
	);

	// Owner passes only while its route still points here
	assign fwd_en = gnt_o.valid && route_hit[gnt_o.master];

	wb_grant_mux #(
		.N (`WB_N_MASTERS),
		.T (wb_req_t)
	) i_req_mux (
		.data_i (req_i),
		.sel_i  (gnt_o.master),
		.en_i   (fwd_en),
		.data_o (req_o)
	);

endmodule

`default_nettype wire

// ==== wb_xbar_consts.svh ====
////////////////////
// Bus widths, port counts and the
// slave 0 address window of the
// Wishbone 3x1 interconnect
////////////////////

`ifndef WB_XBAR_CONSTS_SVH
`define WB_XBAR_CONSTS_SVH

// Wishbone address and data widths
`define WB_ADDR_W 32
`define WB_DATA_W 32

// Masters on the shared bus, and targets behind it
`define WB_N_MASTERS 3
`define WB_N_TARGETS 2

// Inclusive window decoded to slave 0
`define WB_S0_BASE  32'h0000_0000
`define WB_S0_LIMIT 32'h0000_0FFF

`endif
